/* verilog/d0_pkg.sv */
// L1 data cache d0 stage package with cache geometry, request encodings and request bundles
package d0_pkg;

  // Cache geometry for a 16-set cache with 64-byte lines
  localparam int ADDR_W   = 32;
  localparam int OFFSET_W = 6;
  localparam int INDEX_W  = 4;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int NUM_SETS = 1 << INDEX_W;

  // A physical address split into the fields the arrays are indexed with
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } addr_t;

  // Requester that won the d0 slot in the current cycle
  typedef enum logic [2:0] {
    None,
    RstBlock,
    D1,
    L2Cache,
    UpdateL2,
    LSQ
  } d0_winner_e;

  // Kinds of request the LSQ can present
  typedef enum logic [1:0] {
    NoLsq,
    Load,
    Store
  } lsq_d0_req_type_e;

  // Kinds of answer coming back from the L2 cache
  typedef enum logic [1:0] {
    NoAns,
    ReplaceLine,
    StoreHit,
    WWBWakeUp
  } l2c_d0_ans_type_e;

  // Kinds of replay or write-back request coming from d1
  typedef enum logic [2:0] {
    NoD1,
    LoadReplay,
    StoreReplay,
    WriteCleanLine,
    WriteDirtyLine,
    WriteStore,
    CleanDirty,
    WaitL2UpdatingCnt
  } d1_d0_req_type_e;

  // Action performed by d0 on the arrays
  typedef enum logic [3:0] {
    d0_Idle,
    d0_ReadLsq,
    d0_ReadUpdate,
    d0_ReadL2,
    d0_FwdL2StAddr,
    d0_ReadD1,
    d0_WriteCleanLineD1,
    d0_WriteDirtyLineD1,
    d0_WriteStoreD1,
    d0_CleanDirty,
    d0_ResetLines
  } d0_req_type_e;

  // Operation that d1 carries out on the following cycle
  typedef enum logic [2:0] {
    d0_d1_Idle,
    d0_d1_Load,
    d0_d1_Store,
    d0_d1_UpdateL2,
    d0_d1_ReplaceReq,
    d0_d1_L2StHit,
    d0_d1_L2WBBWakeUp
  } d0_d1_req_type_e;

  // Requester bundles, each one held stable until its grant strobe is seen
  typedef struct packed {
    logic             valid;
    lsq_d0_req_type_e kind;
    addr_t            addr;
  } lsq_req_t;

  typedef struct packed {
    logic             valid;
    l2c_d0_ans_type_e kind;
    addr_t            addr;
  } l2c_ans_t;

  typedef struct packed {
    logic            valid;
    d1_d0_req_type_e kind;
    addr_t           addr;
  } d1_req_t;

  // The update counter only names a set, the line address is rebuilt in d0
  typedef struct packed {
    logic               valid;
    logic [INDEX_W-1:0] index;
  } upd_req_t;

  // One grant strobe per external requester
  typedef struct packed {
    logic d1;
    logic l2c;
    logic upd;
    logic lsq;
  } d0_gnt_t;

  // Operation word handed from d0 to d1
  typedef struct packed {
    d0_req_type_e    d0_kind;
    d0_d1_req_type_e d1_next_kind;
    addr_t           addr;
  } d0_op_t;

endpackage

/* verilog/d0_scheduler.sv */
// Fixed-priority d0 scheduler that picks one requester per cycle and strobes its grant
`timescale 1ns/1ns

module d0_scheduler import d0_pkg::*; (
  input  lsq_req_t   lsq_req_i,
  input  l2c_ans_t   l2c_ans_i,
  input  d1_req_t    d1_req_i,
  input  upd_req_t   upd_req_i,
  input  logic       rst_req_i,
  input  logic       stall_i,
  output d0_winner_e winner_o,
  output d0_gnt_t    gnt_o
);

  // The reset sweep blocks everybody else, then d1 replays come before
  // L2 answers, the update counter and finally new LSQ traffic
  always_comb begin
    winner_o = None;
    gnt_o    = '0;
    if (!stall_i) begin
      if (rst_req_i) begin
        // The sweep owns the arrays, so nobody is granted
        winner_o = RstBlock;
      end else if (d1_req_i.valid) begin
        winner_o = D1;
        gnt_o.d1 = 1'b1;
      end else if (l2c_ans_i.valid) begin
        winner_o  = L2Cache;
        gnt_o.l2c = 1'b1;
      end else if (upd_req_i.valid) begin
        winner_o  = UpdateL2;
        gnt_o.upd = 1'b1;
      end else if (lsq_req_i.valid) begin
        winner_o  = LSQ;
        gnt_o.lsq = 1'b1;
      end
    end
    // While d1 stalls the winner stays None and every grant stays low
  end

endmodule

/* verilog/d0_req_encoder.sv */
// Request encoder that turns the scheduled requester and its kind into d0 and d1 actions
`timescale 1ns/1ns

module d0_req_encoder import d0_pkg::*; (
  input  d0_winner_e       winner_i,
  input  d1_d0_req_type_e  d1_req_type_i,
  input  l2c_d0_ans_type_e l2c_ans_type_i,
  input  lsq_d0_req_type_e lsq_req_type_i,
  output d0_req_type_e     d0_req_type_o,
  output d0_d1_req_type_e  d1_next_req_type_o
);

  always_comb begin
    // Anything not listed below leaves both stages idle
    d0_req_type_o      = d0_Idle;
    d1_next_req_type_o = d0_d1_Idle;
    case (winner_i)
      RstBlock: begin
        // Invalidate the whole set, d1 has nothing to do
        d0_req_type_o = d0_ResetLines;
      end
      D1: begin
        case (d1_req_type_i)
          // Replays read the arrays again with the d1 address
          LoadReplay: begin
            d0_req_type_o      = d0_ReadD1;
            d1_next_req_type_o = d0_d1_Load;
          end
          StoreReplay: begin
            d0_req_type_o      = d0_ReadD1;
            d1_next_req_type_o = d0_d1_Store;
          end
          // Line and doubleword writes finish in d0
          WriteCleanLine: begin
            d0_req_type_o = d0_WriteCleanLineD1;
          end
          WriteDirtyLine: begin
            d0_req_type_o = d0_WriteDirtyLineD1;
          end
          WriteStore: begin
            d0_req_type_o = d0_WriteStoreD1;
          end
          CleanDirty: begin
            d0_req_type_o = d0_CleanDirty;
          end
          // WaitL2UpdatingCnt is granted but only burns the slot
          default: begin
            d0_req_type_o      = d0_Idle;
            d1_next_req_type_o = d0_d1_Idle;
          end
        endcase
      end
      L2Cache: begin
        case (l2c_ans_type_i)
          // A refill line arrives, d1 checks whether the victim is dirty
          ReplaceLine: begin
            d0_req_type_o      = d0_ReadL2;
            d1_next_req_type_o = d0_d1_ReplaceReq;
          end
          // Store hit and write-back wake-up only forward the address
          StoreHit: begin
            d0_req_type_o      = d0_FwdL2StAddr;
            d1_next_req_type_o = d0_d1_L2StHit;
          end
          WWBWakeUp: begin
            d0_req_type_o      = d0_FwdL2StAddr;
            d1_next_req_type_o = d0_d1_L2WBBWakeUp;
          end
          default: begin
            d0_req_type_o      = d0_Idle;
            d1_next_req_type_o = d0_d1_Idle;
          end
        endcase
      end
      UpdateL2: begin
        // Read the set named by the counter, d1 drains the buffer into L2
        d0_req_type_o      = d0_ReadUpdate;
        d1_next_req_type_o = d0_d1_UpdateL2;
      end
      LSQ: begin
        // Loads and stores both read in d0 and split in d1
        if (lsq_req_type_i == Load) begin
          d0_req_type_o      = d0_ReadLsq;
          d1_next_req_type_o = d0_d1_Load;
        end else if (lsq_req_type_i == Store) begin
          d0_req_type_o      = d0_ReadLsq;
          d1_next_req_type_o = d0_d1_Store;
        end
      end
      default: begin
        d0_req_type_o      = d0_Idle;
        d1_next_req_type_o = d0_d1_Idle;
      end
    endcase
  end

endmodule

/* verilog/d0_rst_block.sv */
// Post-reset sweep that requests line invalidation for every cache set in turn
`timescale 1ns/1ns

module d0_rst_block import d0_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               stall_i,
  output logic               rst_req_o,
  output logic [INDEX_W-1:0] rst_index_o,
  output logic               rst_done_o
);

  logic [INDEX_W-1:0] index_q;
  logic               done_q;
  logic               last_set;

  // The set being issued this cycle is the final one of the cache
  assign last_set = (index_q == INDEX_W'(NUM_SETS - 1));

  // Set index and done flag of the sweep
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      index_q <= '0;
      done_q  <= 1'b0;
    end else if (!done_q && !stall_i) begin
      // One set is consumed per unstalled cycle
      if (last_set) begin
        done_q <= 1'b1;
      end else begin
        index_q <= index_q + INDEX_W'(1);
      end
    end
  end

  // Requesting is simply the sweep not being finished yet
  assign rst_req_o   = ~done_q;
  assign rst_index_o = index_q;
  assign rst_done_o  = done_q;

endmodule

/* verilog/d0_out_regs.sv */
// d0 output register stage that picks the operation address and latches the op word
`timescale 1ns/1ns

module d0_out_regs import d0_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               stall_i,
  input  d0_winner_e         winner_i,
  input  d0_req_type_e       d0_req_type_i,
  input  d0_d1_req_type_e    d1_next_req_type_i,
  input  addr_t              lsq_addr_i,
  input  addr_t              l2c_addr_i,
  input  addr_t              d1_addr_i,
  input  logic [INDEX_W-1:0] upd_index_i,
  input  logic [INDEX_W-1:0] rst_index_i,
  output d0_op_t             d0_op_o,
  output logic               op_valid_o
);

  addr_t  sel_addr;
  d0_op_t op_d;
  d0_op_t op_q;

  // Address source follows the winner
  always_comb begin
    sel_addr = '0;
    case (winner_i)
      LSQ:     sel_addr = lsq_addr_i;
      L2Cache: sel_addr = l2c_addr_i;
      D1:      sel_addr = d1_addr_i;
      // Set-wide operations only need the index, tag and offset stay zero
      UpdateL2: begin
        sel_addr.index = upd_index_i;
      end
      RstBlock: begin
        sel_addr.index = rst_index_i;
      end
      default: sel_addr = '0;
    endcase
  end

  // Assemble the next word from the encoder outputs and the chosen address
  always_comb begin
    op_d.d0_kind      = d0_req_type_i;
    op_d.d1_next_kind = d1_next_req_type_i;
    op_d.addr         = sel_addr;
  end

  // A stalled d1 keeps the operation it already has
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_q <= '{d0_kind: d0_Idle, d1_next_kind: d0_d1_Idle, addr: '0};
    end else if (!stall_i) begin
      op_q <= op_d;
    end
  end

  assign d0_op_o = op_q;

  // An idle word carries nothing for d1
  assign op_valid_o = (op_q.d0_kind != d0_Idle);

endmodule

/* verilog/d0_stage.sv */
// L1 data cache d0 stage top level joining sweep, scheduler, encoder and output registers
`timescale 1ns/1ns

module d0_stage import d0_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  lsq_req_t lsq_req_i,
  input  l2c_ans_t l2c_ans_i,
  input  d1_req_t  d1_req_i,
  input  upd_req_t upd_req_i,
  input  logic     stall_i,
  output d0_gnt_t  gnt_o,
  output d0_op_t   d0_op_o,
  output logic     op_valid_o,
  output logic     rst_done_o
);

  logic               rst_req;
  logic [INDEX_W-1:0] rst_index;
  d0_winner_e         winner;
  d0_req_type_e       d0_req_type;
  d0_d1_req_type_e    d1_next_req_type;

  // Reset sweep over all sets
  d0_rst_block u_rst_block (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .stall_i     (stall_i),
    .rst_req_o   (rst_req),
    .rst_index_o (rst_index),
    .rst_done_o  (rst_done_o)
  );

  // Pick this cycle's winner and strobe its grant
  d0_scheduler u_scheduler (
    .lsq_req_i (lsq_req_i),
    .l2c_ans_i (l2c_ans_i),
    .d1_req_i  (d1_req_i),
    .upd_req_i (upd_req_i),
    .rst_req_i (rst_req),
    .stall_i   (stall_i),
    .winner_o  (winner),
    .gnt_o     (gnt_o)
  );

  // Translate the winner into the d0 action and the next d1 action
  d0_req_encoder u_req_encoder (
    .winner_i           (winner),
    .d1_req_type_i      (d1_req_i.kind),
    .l2c_ans_type_i     (l2c_ans_i.kind),
    .lsq_req_type_i     (lsq_req_i.kind),
    .d0_req_type_o      (d0_req_type),
    .d1_next_req_type_o (d1_next_req_type)
  );

  // Latch the operation word towards d1
  d0_out_regs u_out_regs (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .stall_i            (stall_i),
    .winner_i           (winner),
    .d0_req_type_i      (d0_req_type),
    .d1_next_req_type_i (d1_next_req_type),
    .lsq_addr_i         (lsq_req_i.addr),
    .l2c_addr_i         (l2c_ans_i.addr),
    .d1_addr_i          (d1_req_i.addr),
    .upd_index_i        (upd_req_i.index),
    .rst_index_i        (rst_index),
    .d0_op_o            (d0_op_o),
    .op_valid_o         (op_valid_o)
  );

endmodule

/* test/tb_d0_stage.sv */
// Testbench for the d0 stage that checks sweep, priority, encoding, address and stall
`timescale 1ns/1ns

module tb_d0_stage import d0_pkg::*; ();

  // Expected grants for this cycle and the op word for the next edge
  typedef struct packed {
    d0_gnt_t gnt;
    d0_op_t  op;
  } expect_t;

  logic               clk_i;
  logic               rst_n_i;
  logic               stall_i;
  lsq_req_t           lsq_req;
  l2c_ans_t           l2c_req;
  d1_req_t            d1_req;
  upd_req_t           upd_req;
  d0_gnt_t            gnt_o;
  d0_op_t             d0_op_o;
  logic               op_valid_o;
  logic               rst_done_o;
  logic [31:0]        lfsr_state;
  logic [INDEX_W-1:0] sweep_idx;
  logic               sweep_done;
  d0_op_t             exp_op;
  expect_t            exp_now;

  d0_stage uut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .lsq_req_i  (lsq_req),
    .l2c_ans_i  (l2c_req),
    .d1_req_i   (d1_req),
    .upd_req_i  (upd_req),
    .stall_i    (stall_i),
    .gnt_o      (gnt_o),
    .d0_op_o    (d0_op_o),
    .op_valid_o (op_valid_o),
    .rst_done_o (rst_done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Galois LFSR stepped once for every bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  function automatic lsq_req_t rand_lsq();
    lsq_req_t r;
    r.valid = rand_bits(1) != 0;
    r.kind  = lsq_d0_req_type_e'(2'(rand_bits(2)));
    r.addr  = addr_t'(rand_bits(32));
    return r;
  endfunction

  function automatic l2c_ans_t rand_l2c();
    l2c_ans_t r;
    r.valid = rand_bits(1) != 0;
    r.kind  = l2c_d0_ans_type_e'(2'(rand_bits(2)));
    r.addr  = addr_t'(rand_bits(32));
    return r;
  endfunction

  function automatic d1_req_t rand_d1();
    d1_req_t r;
    r.valid = rand_bits(1) != 0;
    r.kind  = d1_d0_req_type_e'(3'(rand_bits(3)));
    r.addr  = addr_t'(rand_bits(32));
    return r;
  endfunction

  function automatic upd_req_t rand_upd();
    upd_req_t r;
    r.valid = rand_bits(1) != 0;
    r.index = INDEX_W'(rand_bits(INDEX_W));
    return r;
  endfunction

  function automatic d0_op_t idle_op();
    d0_op_t o;
    o.d0_kind      = d0_Idle;
    o.d1_next_kind = d0_d1_Idle;
    o.addr         = '0;
    return o;
  endfunction

  // Reference model of the stage with the sweep first, then d1, L2, update and LSQ
  function automatic expect_t ref_model(input lsq_req_t lsq, input l2c_ans_t l2c,
                                        input d1_req_t d1, input upd_req_t upd,
                                        input logic stall, input logic done,
                                        input logic [INDEX_W-1:0] sidx);
    expect_t e;
    e.gnt = '0;
    e.op  = idle_op();
    if (stall) begin
      return e;
    end
    if (!done) begin
      e.op.d0_kind    = d0_ResetLines;
      e.op.addr.index = sidx;
    end else if (d1.valid) begin
      e.gnt.d1  = 1'b1;
      e.op.addr = d1.addr;
      case (d1.kind)
        LoadReplay:     {e.op.d0_kind, e.op.d1_next_kind} = {d0_ReadD1, d0_d1_Load};
        StoreReplay:    {e.op.d0_kind, e.op.d1_next_kind} = {d0_ReadD1, d0_d1_Store};
        WriteCleanLine: e.op.d0_kind = d0_WriteCleanLineD1;
        WriteDirtyLine: e.op.d0_kind = d0_WriteDirtyLineD1;
        WriteStore:     e.op.d0_kind = d0_WriteStoreD1;
        CleanDirty:     e.op.d0_kind = d0_CleanDirty;
        default:        e.op.d0_kind = d0_Idle;
      endcase
    end else if (l2c.valid) begin
      e.gnt.l2c = 1'b1;
      e.op.addr = l2c.addr;
      case (l2c.kind)
        ReplaceLine: {e.op.d0_kind, e.op.d1_next_kind} = {d0_ReadL2, d0_d1_ReplaceReq};
        StoreHit:    {e.op.d0_kind, e.op.d1_next_kind} = {d0_FwdL2StAddr, d0_d1_L2StHit};
        WWBWakeUp:   {e.op.d0_kind, e.op.d1_next_kind} = {d0_FwdL2StAddr, d0_d1_L2WBBWakeUp};
        default:     e.op.d0_kind = d0_Idle;
      endcase
    end else if (upd.valid) begin
      e.gnt.upd       = 1'b1;
      e.op.d0_kind    = d0_ReadUpdate;
      e.op.d1_next_kind = d0_d1_UpdateL2;
      e.op.addr.index = upd.index;
    end else if (lsq.valid) begin
      e.gnt.lsq = 1'b1;
      e.op.addr = lsq.addr;
      if (lsq.kind == Load) begin
        {e.op.d0_kind, e.op.d1_next_kind} = {d0_ReadLsq, d0_d1_Load};
      end else if (lsq.kind == Store) begin
        {e.op.d0_kind, e.op.d1_next_kind} = {d0_ReadLsq, d0_d1_Store};
      end
    end
    return e;
  endfunction

  task automatic fail_run(input string why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  task automatic check_gnt(input d0_gnt_t got, input d0_gnt_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: grants %b, expected %b", $time, got, exp);
      fail_run("grant strobes did not match the reference model");
    end
  endtask

  task automatic check_op(input d0_op_t got, input logic got_valid, input d0_op_t exp);
    if (got !== exp || got_valid !== (exp.d0_kind != d0_Idle)) begin
      $display("** Error at %0t ns: op %h valid %b, expected op %h", $time, got, got_valid,
               exp);
      fail_run("registered operation did not match the reference model");
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: rst_done_o %b, expected %b", $time, got, exp);
      fail_run("sweep done flag did not match the reference model");
    end
  endtask

  // Compare at every falling edge where inputs and registers have both settled
  initial begin
    sweep_idx  = '0;
    sweep_done = 1'b0;
    exp_op     = idle_op();
    forever begin
      @(negedge clk_i);
      if (!rst_n_i) begin
        sweep_idx  = '0;
        sweep_done = 1'b0;
        exp_op     = idle_op();
        check_op(d0_op_o, op_valid_o, exp_op);
        check_done(rst_done_o, 1'b0);
      end else begin
        check_op(d0_op_o, op_valid_o, exp_op);
        check_done(rst_done_o, sweep_done);
        exp_now = ref_model(lsq_req, l2c_req, d1_req, upd_req, stall_i, sweep_done, sweep_idx);
        check_gnt(gnt_o, exp_now.gnt);
        if (!stall_i) begin
          exp_op = exp_now.op;
          if (!sweep_done && sweep_idx == INDEX_W'(NUM_SETS - 1)) begin
            sweep_done = 1'b1;
          end else if (!sweep_done) begin
            sweep_idx = sweep_idx + INDEX_W'(1);
          end
        end
      end
    end
  end

  // One cycle of stimulus where granted requesters drop and refill draws new random ones
  task automatic next_cycle(input logic refill);
    d0_gnt_t g;
    @(negedge clk_i);
    g = gnt_o;
    @(posedge clk_i);
    #2;
    if (g.d1) d1_req.valid = 1'b0;
    if (g.l2c) l2c_req.valid = 1'b0;
    if (g.upd) upd_req.valid = 1'b0;
    if (g.lsq) lsq_req.valid = 1'b0;
    if (refill) begin
      if (!d1_req.valid) d1_req = rand_d1();
      if (!l2c_req.valid) l2c_req = rand_l2c();
      if (!upd_req.valid) upd_req = rand_upd();
      if (!lsq_req.valid) lsq_req = rand_lsq();
      stall_i = (3'(rand_bits(3)) == 3'd0);
    end
  endtask

  task automatic wait_idle(input int limit, input string what);
    int n;
    n = 0;
    while (lsq_req.valid || l2c_req.valid || d1_req.valid || upd_req.valid) begin
      if (n >= limit) begin
        fail_run({"timed out waiting for ", what, " to be granted"});
      end else begin
        next_cycle(1'b0);
        n++;
      end
    end
    // One more edge so the last operation reaches the output register
    next_cycle(1'b0);
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (!rst_done_o) begin
      if (n >= limit) begin
        fail_run("timed out waiting for the reset sweep to finish");
      end else begin
        next_cycle(1'b0);
        n++;
      end
    end
  endtask

  task automatic load_all();
    d1_req  = '{valid: 1'b1, kind: LoadReplay, addr: addr_t'(rand_bits(32))};
    l2c_req = '{valid: 1'b1, kind: ReplaceLine, addr: addr_t'(rand_bits(32))};
    upd_req = '{valid: 1'b1, index: INDEX_W'(rand_bits(INDEX_W))};
    lsq_req = '{valid: 1'b1, kind: Store, addr: addr_t'(rand_bits(32))};
  endtask

  initial begin
    lfsr_state = 32'h07d7_8df9;
    rst_n_i    = 1'b0;
    stall_i    = 1'b0;
    lsq_req    = '0;
    l2c_req    = '0;
    d1_req     = '0;
    upd_req    = '0;
    // Everybody is already asking while the sweep runs
    load_all();
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    repeat (5) next_cycle(1'b0);
    // A stall in the middle of the sweep must resume at the next set
    stall_i = 1'b1;
    repeat (3) next_cycle(1'b0);
    stall_i = 1'b0;
    wait_done(40);
    // The held requests now drain in priority order
    wait_idle(10, "all four requesters");
    load_all();
    d1_req.valid = 1'b0;
    wait_idle(10, "L2, update and LSQ");
    // Every kind alone with a fresh address each time
    for (int k = 0; k < 8; k++) begin
      d1_req = '{valid: 1'b1, kind: d1_d0_req_type_e'(k[2:0]), addr: addr_t'(rand_bits(32))};
      wait_idle(4, "a d1 request");
    end
    for (int k = 0; k < 4; k++) begin
      l2c_req = '{valid: 1'b1, kind: l2c_d0_ans_type_e'(k[1:0]), addr: addr_t'(rand_bits(32))};
      wait_idle(4, "an L2 answer");
      lsq_req = '{valid: 1'b1, kind: lsq_d0_req_type_e'(k[1:0]), addr: addr_t'(rand_bits(32))};
      wait_idle(4, "an LSQ request");
    end
    upd_req = '{valid: 1'b1, index: INDEX_W'(rand_bits(INDEX_W))};
    wait_idle(4, "an update request");
    // Stall right after a granted LSQ load so the held word is a real operation
    lsq_req = '{valid: 1'b1, kind: Load, addr: addr_t'(rand_bits(32))};
    next_cycle(1'b0);
    // A pending LSQ store waits out the stall and then goes through
    lsq_req = '{valid: 1'b1, kind: Store, addr: addr_t'(rand_bits(32))};
    stall_i = 1'b1;
    repeat (4) next_cycle(1'b0);
    stall_i = 1'b0;
    wait_idle(4, "the stalled LSQ request");
    repeat (2000) next_cycle(1'b1);
    stall_i = 1'b0;
    wait_idle(10, "the last random requests");
    $display("** PASS **");
    $finish;
  end

endmodule

/* tb.f */
verilog/d0_pkg.sv
verilog/d0_scheduler.sv
verilog/d0_req_encoder.sv
verilog/d0_rst_block.sv
verilog/d0_out_regs.sv
verilog/d0_stage.sv
test/tb_d0_stage.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f tb.f --top-module tb_d0_stage -Mdir obj_dir -o tb_d0_stage &&
./obj_dir/tb_d0_stage || exit 1
